// ==== bench/proc_model.svh ====
// Instruction-set model, run once per accepted instruction in program order

typedef struct packed {
	logic        cv;		// Commit expected
	logic [4:0]  ca;
	logic [31:0] cd;
	logic        ov;		// OUT expected
	logic [31:0] od;
} expect_t;

logic [31:0] model_regs [32];

function automatic void model_reset();
	for (int i = 0; i < 32; i++)
		model_regs[i] = '0;
endfunction

// ALU behavior indexed by R-type function code
function automatic logic [31:0] alu_model(input logic [5:0] fn, input logic [31:0] a, b);
	case (fn)
		proc_pkg::FN_ADD:  return a + b;
		proc_pkg::FN_SUB:  return a - b;
		proc_pkg::FN_MUL:  return a * b;
		proc_pkg::FN_DIV:  return (b == 0) ? proc_pkg::DIV_ZERO_RESULT : a / b;
		proc_pkg::FN_MOD:  return (b == 0) ? a : a % b;
		proc_pkg::FN_AND:  return a & b;
		proc_pkg::FN_OR:   return a | b;
		proc_pkg::FN_XOR:  return a ^ b;
		proc_pkg::FN_LAND: return {31'd0, (a != 0) && (b != 0)};
		proc_pkg::FN_LOR:  return {31'd0, (a != 0) || (b != 0)};
		proc_pkg::FN_SLL:  return a << b[4:0];
		proc_pkg::FN_SRL:  return a >> b[4:0];
		proc_pkg::FN_EQ:   return {31'd0, a == b};
		proc_pkg::FN_NE:   return {31'd0, a != b};
		proc_pkg::FN_LT:   return {31'd0, $signed(a) < $signed(b)};
		proc_pkg::FN_LE:   return {31'd0, $signed(a) <= $signed(b)};
		proc_pkg::FN_GT:   return {31'd0, $signed(a) > $signed(b)};
		proc_pkg::FN_GE:   return {31'd0, $signed(a) >= $signed(b)};
		default:           return '0;
	endcase
endfunction

function automatic expect_t model_step(input logic valid, input logic [31:0] word);
	expect_t     e;
	logic [5:0]  op;
	logic [4:0]  rs, rt, dest;
	logic [31:0] a, imm, res;
	logic        wr;
	e    = '0;
	op   = word[31:26];
	rs   = word[25:21];
	rt   = word[20:16];
	imm  = {{16{word[15]}}, word[15:0]};
	a    = model_regs[rs];
	dest = rt;				// I-type default
	res  = '0;
	wr   = 1'b1;
	if (!valid)
		return e;
	case (op)
		proc_pkg::OP_RTYPE: begin
			dest = word[15:11];
			if (word[5:0] <= 6'd17)
				res = alu_model(word[5:0], a, model_regs[rt]);
			else
				wr = 1'b0;			// JR and unused function codes
		end
		proc_pkg::OP_NOT: res = ~a;
		proc_pkg::OP_MOV: res = a;
		proc_pkg::OP_LI:  res = imm;
		proc_pkg::OP_OUT: begin
			wr   = 1'b0;
			e.ov = 1'b1;
			e.od = a;
		end
		default: begin
			// I-type codes follow the function order, with NOT in the gap
			if (op >= proc_pkg::OP_ADDI && op <= proc_pkg::OP_SRLI)
				res = alu_model(op < proc_pkg::OP_NOT ? op - 6'd1 : op - 6'd2, a, imm);
			else
				wr = 1'b0;
		end
	endcase
	if (wr && dest != 0) begin
		model_regs[dest] = res;
		e.cv = 1'b1;
		e.ca = dest;
		e.cd = res;
	end
	return e;
endfunction

// ==== bench/tb_proc_core.sv ====
`timescale 1ns/1ps

module tb_proc_core;

	`include "proc_model.svh"

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        commit_valid;
	logic [4:0]  commit_addr;
	logic [31:0] commit_data;
	logic        out_valid;
	logic [31:0] out_data;

	expect_t exp_q[$];			// One entry per sampled cycle
	expect_t due;
	bit      mon_on;
	int      commits_seen;
	int      outs_seen;

	proc_core dut (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_instr_valid  (instr_valid),
		.i_instr        (instr),
		.o_commit_valid (commit_valid),
		.o_commit_addr  (commit_addr),
		.o_commit_data  (commit_data),
		.o_out_valid    (out_valid),
		.o_out_data     (out_data)
	);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "stopping simulation");
	endtask

	task automatic report_value(input string name, input logic [31:0] exp, act);
		$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		abort_run();
	endtask

	task automatic check_outputs(input expect_t e);
		assert (commit_valid === e.cv) else report_value("o_commit_valid", e.cv, commit_valid);
		if (e.cv) begin
			assert (commit_addr === e.ca) else report_value("o_commit_addr", e.ca, commit_addr);
			assert (commit_data === e.cd) else report_value("o_commit_data", e.cd, commit_data);
			commits_seen++;
		end
		assert (out_valid === e.ov) else report_value("o_out_valid", e.ov, out_valid);
		if (e.ov) begin
			assert (out_data === e.od) else report_value("o_out_data", e.od, out_data);
			outs_seen++;
		end
	endtask

	// Outputs after edge m belong to the input sampled two negedges earlier
	always @(negedge clk) begin
		if (mon_on) begin
			due = (exp_q.size() >= 2) ? exp_q.pop_front() : '0;
			check_outputs(due);
			exp_q.push_back(model_step(instr_valid, instr));
		end
	end

	function automatic int pending_count();
		int n;
		n = 0;
		foreach (exp_q[i])
			if (exp_q[i].cv || exp_q[i].ov)
				n++;
		return n;
	endfunction

	task automatic send(input logic valid, input logic [31:0] word);
		@(posedge clk);
		instr_valid <= valid;
		instr       <= word;
	endtask

	// Random R-type or I-type ALU instruction with fairly frequent zero divisors
	function automatic logic [31:0] alu_instr(input logic [4:0] rs, rt, dst);
		logic [15:0] imm;
		imm = ($urandom_range(0, 5) == 0) ? 16'd0 : 16'($urandom);
		if ($urandom_range(0, 1) == 1)
			return {6'd0, rs, rt, dst, 5'd0, 6'($urandom_range(0, 17))};
		return {6'($urandom_range(1, 13)), rs, dst, imm};
	endfunction

	function automatic logic [4:0] pick_reg();
		return ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
	endfunction

	task automatic drain();
		int cycles;
		cycles = 0;
		while (pending_count() != 0) begin
			send(1'b0, '0);
			cycles++;
			if (cycles > 20) begin
				$display("Timeout: results still outstanding after %0d idle cycles", cycles);
				abort_run();
			end
		end
	endtask

	initial begin
		logic [4:0] prev1, prev2, dst;
		logic [5:0] op;
		clk          = 1'b0;
		rst_n        = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		mon_on       = 1'b0;
		commits_seen = 0;
		outs_seen    = 0;
		prev1        = 5'd1;
		prev2        = 5'd2;
		void'($urandom(32'h1948));
		model_reset();
		repeat (8) @(posedge clk);
		rst_n  <= 1'b1;
		mon_on = 1'b1;

		repeat (4) send(1'b0, $urandom);	// Idle cycles give no output
		repeat (8)				// Registers read zero after reset
			send(1'b1, {proc_pkg::OP_MOV, 5'($urandom), 5'($urandom_range(1, 31)), 16'($urandom)});
		for (int r = 1; r < 32; r++)
			send(1'b1, {proc_pkg::OP_LI, 5'($urandom), 5'(r), 16'($urandom)});

		repeat (300)				// Random ALU ops with gaps
			send($urandom_range(0, 4) != 0, alu_instr(pick_reg(), pick_reg(), 5'($urandom)));

		repeat (300) begin			// Chains on the last two destinations
			dst = 5'($urandom_range(1, 31));
			if ($urandom_range(0, 1) == 1)
				send(1'b1, alu_instr(prev1, prev2, dst));
			else
				send(1'b1, alu_instr(prev2, prev1, dst));
			prev2 = prev1;
			prev1 = dst;
		end

		repeat (40) begin			// OUT and writes to r0
			send(1'b1, {proc_pkg::OP_OUT, 5'($urandom), 21'($urandom)});
			send(1'b1, alu_instr(pick_reg(), pick_reg(), 5'd0));
		end

		repeat (100) begin			// Excluded opcodes between live ones
			op = 6'($urandom_range(15, 63));
			if (op == proc_pkg::OP_LI || op == proc_pkg::OP_OUT)
				op = proc_pkg::OP_LW;
			send(1'b1, {op, 26'($urandom)});
			send(1'b0, $urandom);
			send(1'b1, alu_instr(pick_reg(), pick_reg(), 5'($urandom)));
		end

		drain();
		if (commits_seen > 0 && outs_seen > 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("No commit or OUT result was ever checked");
			abort_run();
		end
	end

endmodule

// ==== proc_core.f ====
+incdir+bench
source/proc_pkg.sv
source/stage_ifs.sv
source/control_unit.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/proc_core.sv
bench/tb_proc_core.sv

// ==== source/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input  proc_pkg::opcode_t i_op,
	input  proc_pkg::func_t   i_func,
	output proc_pkg::alu_op_t o_alu_op,
	output logic              o_reg_write,
	output logic              o_out_write,
	output logic              o_use_reg_b,		// 1 takes rt, 0 takes the immediate
	output logic              o_dest_is_rt		// 1 writes rt, 0 writes rd
);

	always_comb begin
		o_alu_op     = proc_pkg::ALU_PASS_A;
		o_reg_write  = 1'b0;
		o_out_write  = 1'b0;
		o_use_reg_b  = 1'b0;
		o_dest_is_rt = 1'b0;

		// Write and operand controls
		case (i_op)
			proc_pkg::OP_RTYPE: begin
				o_use_reg_b = 1'b1;
				o_reg_write = 1'b1;
			end
			proc_pkg::OP_ADDI, proc_pkg::OP_SUBI, proc_pkg::OP_MULI, proc_pkg::OP_DIVI,
			proc_pkg::OP_MODI, proc_pkg::OP_ANDI, proc_pkg::OP_ORI, proc_pkg::OP_XORI,
			proc_pkg::OP_LANDI, proc_pkg::OP_LORI, proc_pkg::OP_SLLI, proc_pkg::OP_SRLI,
			proc_pkg::OP_NOT, proc_pkg::OP_MOV, proc_pkg::OP_LI: begin
				o_reg_write  = 1'b1;
				o_dest_is_rt = 1'b1;
			end
			proc_pkg::OP_OUT: o_out_write = 1'b1;
			default: ;						// Memory, jumps, MMU, disk and system ops do nothing
		endcase

		// ALU operation
		case (i_op)
			proc_pkg::OP_RTYPE: begin
				case (i_func)
					proc_pkg::FN_ADD:  o_alu_op = proc_pkg::ALU_ADD;
					proc_pkg::FN_SUB:  o_alu_op = proc_pkg::ALU_SUB;
					proc_pkg::FN_MUL:  o_alu_op = proc_pkg::ALU_MUL;
					proc_pkg::FN_DIV:  o_alu_op = proc_pkg::ALU_DIV;
					proc_pkg::FN_MOD:  o_alu_op = proc_pkg::ALU_MOD;
					proc_pkg::FN_AND:  o_alu_op = proc_pkg::ALU_AND;
					proc_pkg::FN_OR:   o_alu_op = proc_pkg::ALU_OR;
					proc_pkg::FN_XOR:  o_alu_op = proc_pkg::ALU_XOR;
					proc_pkg::FN_LAND: o_alu_op = proc_pkg::ALU_LAND;
					proc_pkg::FN_LOR:  o_alu_op = proc_pkg::ALU_LOR;
					proc_pkg::FN_SLL:  o_alu_op = proc_pkg::ALU_SLL;
					proc_pkg::FN_SRL:  o_alu_op = proc_pkg::ALU_SRL;
					proc_pkg::FN_EQ:   o_alu_op = proc_pkg::ALU_EQ;
					proc_pkg::FN_NE:   o_alu_op = proc_pkg::ALU_NE;
					proc_pkg::FN_LT:   o_alu_op = proc_pkg::ALU_LT;
					proc_pkg::FN_LE:   o_alu_op = proc_pkg::ALU_LE;
					proc_pkg::FN_GT:   o_alu_op = proc_pkg::ALU_GT;
					proc_pkg::FN_GE:   o_alu_op = proc_pkg::ALU_GE;
					default: o_reg_write = 1'b0;		// JR and unused codes
				endcase
			end
			proc_pkg::OP_ADDI:  o_alu_op = proc_pkg::ALU_ADD;
			proc_pkg::OP_SUBI:  o_alu_op = proc_pkg::ALU_SUB;
			proc_pkg::OP_MULI:  o_alu_op = proc_pkg::ALU_MUL;
			proc_pkg::OP_DIVI:  o_alu_op = proc_pkg::ALU_DIV;
			proc_pkg::OP_MODI:  o_alu_op = proc_pkg::ALU_MOD;
			proc_pkg::OP_ANDI:  o_alu_op = proc_pkg::ALU_AND;
			proc_pkg::OP_ORI:   o_alu_op = proc_pkg::ALU_OR;
			proc_pkg::OP_XORI:  o_alu_op = proc_pkg::ALU_XOR;
			proc_pkg::OP_LANDI: o_alu_op = proc_pkg::ALU_LAND;
			proc_pkg::OP_LORI:  o_alu_op = proc_pkg::ALU_LOR;
			proc_pkg::OP_SLLI:  o_alu_op = proc_pkg::ALU_SLL;
			proc_pkg::OP_SRLI:  o_alu_op = proc_pkg::ALU_SRL;
			proc_pkg::OP_NOT:   o_alu_op = proc_pkg::ALU_NOT;
			default: o_alu_op = proc_pkg::ALU_PASS_A;	// MOV, LI and OUT pass operand a
		endcase
	end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_instr_valid,
	input  logic [proc_pkg::INSTR_W-1:0] i_instr,
	output logic [proc_pkg::REG_AW-1:0]  o_rd_addr_a,
	output logic [proc_pkg::REG_AW-1:0]  o_rd_addr_b,
	input  logic [proc_pkg::DATA_W-1:0]  i_rd_data_a,
	input  logic [proc_pkg::DATA_W-1:0]  i_rd_data_b,
	exec_if.src                          ex,
	input  logic                         i_fwd_en,		// Execute result due next edge
	input  logic [proc_pkg::REG_AW-1:0]  i_fwd_addr,
	input  logic [proc_pkg::DATA_W-1:0]  i_fwd_data,
	wb_if.fwd                            wb
);

	proc_pkg::opcode_t           op;
	proc_pkg::func_t             func;
	proc_pkg::alu_op_t           alu_op;
	logic [proc_pkg::REG_AW-1:0] rs, rt, rd, dest;
	logic [proc_pkg::IMM_W-1:0]  imm;
	logic [proc_pkg::DATA_W-1:0] imm_ext, rs_val, rt_val, opnd_a, opnd_b;
	logic                        reg_write, out_write, use_reg_b, dest_is_rt, is_li;

	function automatic logic [proc_pkg::DATA_W-1:0] operand_value(
		input logic [proc_pkg::REG_AW-1:0] addr,
		input logic [proc_pkg::DATA_W-1:0] reg_data
	);
		if (i_fwd_en && i_fwd_addr == addr)
			return i_fwd_data;				// Previous instruction
		if (wb.wr_en && wb.wr_addr == addr)
			return wb.wr_data;				// Second previous instruction in writeback
		return reg_data;
	endfunction

	assign op      = proc_pkg::opcode_t'(i_instr[proc_pkg::OP_MSB:proc_pkg::OP_LSB]);
	assign func    = proc_pkg::func_t'(i_instr[proc_pkg::FUNC_W-1:0]);
	assign rs      = i_instr[proc_pkg::RS_MSB -: proc_pkg::REG_AW];
	assign rt      = i_instr[proc_pkg::RT_MSB -: proc_pkg::REG_AW];
	assign rd      = i_instr[proc_pkg::RD_MSB -: proc_pkg::REG_AW];
	assign imm     = i_instr[proc_pkg::IMM_W-1:0];
	assign imm_ext = {{(proc_pkg::DATA_W-proc_pkg::IMM_W){imm[proc_pkg::IMM_W-1]}}, imm};
	assign is_li   = (op == proc_pkg::OP_LI);		// LI sends the immediate down the a path

	assign o_rd_addr_a = rs;
	assign o_rd_addr_b = rt;

	control_unit u_control (
		.i_op         (op),
		.i_func       (func),
		.o_alu_op     (alu_op),
		.o_reg_write  (reg_write),
		.o_out_write  (out_write),
		.o_use_reg_b  (use_reg_b),
		.o_dest_is_rt (dest_is_rt)
	);

	always_comb begin
		rs_val = operand_value(rs, i_rd_data_a);
		rt_val = operand_value(rt, i_rd_data_b);
		opnd_a = is_li ? imm_ext : rs_val;
		opnd_b = use_reg_b ? rt_val : imm_ext;
		dest   = dest_is_rt ? rt : rd;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			ex.valid     <= 1'b0;
			ex.reg_write <= 1'b0;
			ex.out_write <= 1'b0;
		end else begin
			ex.valid     <= i_instr_valid;
			ex.reg_write <= reg_write & (dest != '0);	// r0 never written
			ex.out_write <= out_write;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_instr_valid) begin
			ex.alu_op    <= alu_op;
			ex.operand_a <= opnd_a;
			ex.operand_b <= opnd_b;
			ex.dest      <= dest;
		end
	end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	exec_if.dst                         ex,
	wb_if.src                           wb,
	output logic                        o_fwd_en,
	output logic [proc_pkg::REG_AW-1:0] o_fwd_addr,
	output logic [proc_pkg::DATA_W-1:0] o_fwd_data,
	output logic                        o_out_valid,
	output logic [proc_pkg::DATA_W-1:0] o_out_data
);

	logic [proc_pkg::DATA_W-1:0] opnd_a, opnd_b, alu_result;
	logic [4:0]                  shamt;

	assign opnd_a = ex.operand_a;
	assign opnd_b = ex.operand_b;
	assign shamt  = opnd_b[4:0];			// Shift amount from the low bits

	always_comb begin
		alu_result = '0;
		case (ex.alu_op)
			proc_pkg::ALU_ADD: alu_result = opnd_a + opnd_b;
			proc_pkg::ALU_SUB: alu_result = opnd_a - opnd_b;
			proc_pkg::ALU_MUL: alu_result = opnd_a * opnd_b;	// Low word of the product
			proc_pkg::ALU_DIV:
				alu_result = (opnd_b == '0) ? proc_pkg::DIV_ZERO_RESULT : opnd_a / opnd_b;
			proc_pkg::ALU_MOD: alu_result = (opnd_b == '0) ? opnd_a : opnd_a % opnd_b;
			proc_pkg::ALU_AND: alu_result = opnd_a & opnd_b;
			proc_pkg::ALU_OR:  alu_result = opnd_a | opnd_b;
			proc_pkg::ALU_XOR: alu_result = opnd_a ^ opnd_b;
			proc_pkg::ALU_LAND: alu_result[0] = (opnd_a != '0) && (opnd_b != '0);
			proc_pkg::ALU_LOR:  alu_result[0] = (opnd_a != '0) || (opnd_b != '0);
			proc_pkg::ALU_NOT: alu_result = ~opnd_a;
			proc_pkg::ALU_SLL: alu_result = opnd_a << shamt;
			proc_pkg::ALU_SRL: alu_result = opnd_a >> shamt;
			proc_pkg::ALU_EQ:  alu_result[0] = (opnd_a == opnd_b);
			proc_pkg::ALU_NE:  alu_result[0] = (opnd_a != opnd_b);
			proc_pkg::ALU_LT:  alu_result[0] = ($signed(opnd_a) < $signed(opnd_b));
			proc_pkg::ALU_LE:  alu_result[0] = ($signed(opnd_a) <= $signed(opnd_b));
			proc_pkg::ALU_GT:  alu_result[0] = ($signed(opnd_a) > $signed(opnd_b));
			proc_pkg::ALU_GE:  alu_result[0] = ($signed(opnd_a) >= $signed(opnd_b));
			proc_pkg::ALU_PASS_A: alu_result = opnd_a;
			default: alu_result = '0;
		endcase
	end

	// Next write, seen by decode in the same cycle
	assign o_fwd_en   = ex.valid & ex.reg_write;
	assign o_fwd_addr = ex.dest;
	assign o_fwd_data = alu_result;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wb.wr_en    <= 1'b0;
			o_out_valid <= 1'b0;
		end else begin
			wb.wr_en    <= o_fwd_en;
			o_out_valid <= ex.valid & ex.out_write;
		end
	end

	always_ff @(posedge i_clk) begin
		wb.wr_addr <= ex.dest;
		wb.wr_data <= alu_result;
		o_out_data <= alu_result;			// OUT passes rs through the ALU
	end

endmodule

// ==== source/proc_core.sv ====
`timescale 1ns/1ps

module proc_core (
	input  logic                         i_clk,
	input  logic                         i_rst_n,
	input  logic                         i_instr_valid,
	input  logic [proc_pkg::INSTR_W-1:0] i_instr,
	output logic                         o_commit_valid,
	output logic [proc_pkg::REG_AW-1:0]  o_commit_addr,
	output logic [proc_pkg::DATA_W-1:0]  o_commit_data,
	output logic                         o_out_valid,
	output logic [proc_pkg::DATA_W-1:0]  o_out_data
);

	logic [proc_pkg::REG_AW-1:0] rd_addr_a, rd_addr_b, fwd_addr;
	logic [proc_pkg::DATA_W-1:0] rd_data_a, rd_data_b, fwd_data;
	logic                        fwd_en;

	exec_if ex_bus ();
	wb_if   wb_bus ();

	decode_stage u_decode (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.o_rd_addr_a   (rd_addr_a),
		.o_rd_addr_b   (rd_addr_b),
		.i_rd_data_a   (rd_data_a),
		.i_rd_data_b   (rd_data_b),
		.ex            (ex_bus.src),
		.i_fwd_en      (fwd_en),
		.i_fwd_addr    (fwd_addr),
		.i_fwd_data    (fwd_data),
		.wb            (wb_bus.fwd)
	);

	execute_stage u_execute (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.ex          (ex_bus.dst),
		.wb          (wb_bus.src),
		.o_fwd_en    (fwd_en),
		.o_fwd_addr  (fwd_addr),
		.o_fwd_data  (fwd_data),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	register_file u_regs (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rd_addr_a (rd_addr_a),
		.i_rd_addr_b (rd_addr_b),
		.o_rd_data_a (rd_data_a),
		.o_rd_data_b (rd_data_b),
		.wb          (wb_bus.wr)
	);

	// Commit port mirrors the register write
	assign o_commit_valid = wb_bus.wr_en;
	assign o_commit_addr  = wb_bus.wr_addr;
	assign o_commit_data  = wb_bus.wr_data;

endmodule

// ==== source/proc_pkg.sv ====
package proc_pkg;

	localparam int DATA_W   = 32;			// Data word width
	localparam int INSTR_W  = 32;			// Instruction word width
	localparam int REG_AW   = 5;			// Register address width
	localparam int NUM_REGS = 32;
	localparam int FUNC_W   = 6;			// R-type function field width

	// Instruction field positions
	localparam int OP_MSB = 31;
	localparam int OP_LSB = 26;
	localparam int RS_MSB = 25;
	localparam int RT_MSB = 20;
	localparam int RD_MSB = 15;
	localparam int IMM_W  = 16;

	localparam logic [DATA_W-1:0] DIV_ZERO_RESULT = '1;	// Quotient of a division by zero

	typedef enum logic [OP_MSB-OP_LSB:0] {
		OP_RTYPE = 6'd0,  OP_ADDI = 6'd1,  OP_SUBI = 6'd2,  OP_MULI = 6'd3,
		OP_DIVI  = 6'd4,  OP_MODI = 6'd5,  OP_ANDI = 6'd6,  OP_ORI  = 6'd7,
		OP_XORI  = 6'd8,  OP_NOT  = 6'd9,  OP_LANDI = 6'd10, OP_LORI = 6'd11,
		OP_SLLI  = 6'd12, OP_SRLI = 6'd13, OP_MOV  = 6'd14, OP_LW   = 6'd15,
		OP_LI    = 6'd16, OP_LA   = 6'd17, OP_SW   = 6'd18, OP_IN   = 6'd19,
		OP_OUT   = 6'd20, OP_JF   = 6'd21, OP_J    = 6'd22, OP_JAL  = 6'd23,
		OP_HALT  = 6'd24, OP_LDK  = 6'd25, OP_SDK  = 6'd26, OP_SIM  = 6'd28,
		OP_CKHD  = 6'd29, OP_CKIM = 6'd30, OP_CKDM = 6'd31,
		OP_MMU_LOWER_IM = 6'd32,
		OP_MMU_UPPER_IM = 6'd33,
		OP_MMU_LOWER_DM = 6'd34,
		OP_MMU_UPPER_DM = 6'd35,
		OP_MMU_SELECT   = 6'd36,
		OP_SYSCALL      = 6'd37,
		OP_EXEC         = 6'd38
	} opcode_t;

	typedef enum logic [FUNC_W-1:0] {
		FN_ADD  = 6'd0,  FN_SUB  = 6'd1,  FN_MUL = 6'd2,  FN_DIV = 6'd3,
		FN_MOD  = 6'd4,  FN_AND  = 6'd5,  FN_OR  = 6'd6,  FN_XOR = 6'd7,
		FN_LAND = 6'd8,  FN_LOR  = 6'd9,  FN_SLL = 6'd10, FN_SRL = 6'd11,
		FN_EQ   = 6'd12, FN_NE   = 6'd13, FN_LT  = 6'd14, FN_LE  = 6'd15,
		FN_GT   = 6'd16, FN_GE   = 6'd17
	} func_t;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV, ALU_MOD,
		ALU_AND, ALU_OR, ALU_XOR, ALU_LAND, ALU_LOR,
		ALU_NOT, ALU_SLL, ALU_SRL,
		ALU_EQ, ALU_NE, ALU_LT, ALU_LE, ALU_GT, ALU_GE,
		ALU_PASS_A
	} alu_op_t;

endpackage

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic [proc_pkg::REG_AW-1:0] i_rd_addr_a,
	input  logic [proc_pkg::REG_AW-1:0] i_rd_addr_b,
	output logic [proc_pkg::DATA_W-1:0] o_rd_data_a,
	output logic [proc_pkg::DATA_W-1:0] o_rd_data_b,
	wb_if.wr                            wb
);

	logic [proc_pkg::DATA_W-1:0] regs [proc_pkg::NUM_REGS];

	function automatic logic [proc_pkg::DATA_W-1:0] read_port(
		input logic [proc_pkg::REG_AW-1:0] addr
	);
		if (addr == '0)
			return '0;						// r0 is hardwired
		if (wb.wr_en && wb.wr_addr == addr)
			return wb.wr_data;				// Write-through
		return regs[addr];
	endfunction

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < proc_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb.wr_en && wb.wr_addr != '0) begin
			regs[wb.wr_addr] <= wb.wr_data;
		end
	end

	always_comb begin
		o_rd_data_a = read_port(i_rd_addr_a);
		o_rd_data_b = read_port(i_rd_addr_b);
	end

endmodule

// ==== source/stage_ifs.sv ====
`timescale 1ns/1ps

// Decoded instruction, registered in decode and consumed by execute
interface exec_if;
	logic                              valid;
	proc_pkg::alu_op_t                 alu_op;
	logic [proc_pkg::DATA_W-1:0]       operand_a;
	logic [proc_pkg::DATA_W-1:0]       operand_b;
	logic [proc_pkg::REG_AW-1:0]       dest;
	logic                              reg_write;		// Already cleared for r0
	logic                              out_write;

	modport src (
		output valid, alu_op, operand_a, operand_b, dest, reg_write, out_write
	);

	modport dst (
		input valid, alu_op, operand_a, operand_b, dest, reg_write, out_write
	);
endinterface

// Register write from execute
interface wb_if;
	logic                              wr_en;
	logic [proc_pkg::REG_AW-1:0]       wr_addr;
	logic [proc_pkg::DATA_W-1:0]       wr_data;

	modport src (
		output wr_en, wr_addr, wr_data
	);

	modport wr (
		input wr_en, wr_addr, wr_data
	);

	modport fwd (
		input wr_en, wr_addr, wr_data
	);
endinterface
